//--- hdl/fpu_pkg.sv
// shared widths, lane field sizes and flag indices
// opcode encodings of the logic, permute and compare groups
// vector types for operands, selects, flags and the control word
package fpu_pkg;

  // operand and lane geometry
  localparam int data_w = 64;
  localparam int lane_w = 32;

  // single precision fields inside a lane
  localparam int exp_w = 8;
  localparam int man_w = 23;

  // result buses feeding the bypass network
  localparam int num_bus = 4;

  // raise and enable vectors
  localparam int flag_w = 11;
  localparam int flag_inv = 0;
  localparam int flag_den = 1;

  // exception enables start here in the control word
  localparam int csr_en_lo = 11;

  // upper six opcode bits common to the logic group
  localparam logic [5:0] fop_logic_hi = 6'b000100;

  typedef logic [data_w-1:0] data_t;
  typedef logic [lane_w-1:0] lane_t;
  typedef logic [flag_w-1:0] flags_t;
  typedef logic [num_bus-1:0] bus_sel_t;
  typedef logic [3:0] excno_t;
  typedef logic [31:0] csr_t;
  typedef logic [2:0] mod_t;

  // low two bits of the logic codes pick the function
  typedef enum logic [7:0] {
    fop_and     = 8'h10,
    fop_or      = 8'h11,
    fop_xor     = 8'h12,
    fop_andn    = 8'h13,
    fop_perm    = 8'h20,
    fop_cmpeq_s = 8'h30
  } fop_t;

endpackage

//--- hdl/issue_latch.sv
// issue stage registers of the fp slice
// holds opcode, modifier, operands and bypass selects
// plus the current and previous generation of the result buses
`timescale 1ns/1ns

module issue_latch (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic                                       en,
  input  fpu_pkg::fop_t                              op,
  input  fpu_pkg::mod_t                              mod,
  input  fpu_pkg::data_t                             a,
  input  fpu_pkg::data_t                             b,
  input  fpu_pkg::bus_sel_t                          fwd_a,
  input  fpu_pkg::bus_sel_t                          fwd_b,
  input  fpu_pkg::bus_sel_t                          fwdp_a,
  input  fpu_pkg::bus_sel_t                          fwdp_b,
  input  fpu_pkg::data_t [fpu_pkg::num_bus-1:0]      bus,
  output logic                                       iss_valid,
  output fpu_pkg::fop_t                              iss_op,
  output fpu_pkg::mod_t                              iss_mod,
  output fpu_pkg::data_t                             iss_a,
  output fpu_pkg::data_t                             iss_b,
  output fpu_pkg::bus_sel_t                          iss_fwd_a,
  output fpu_pkg::bus_sel_t                          iss_fwd_b,
  output fpu_pkg::bus_sel_t                          iss_fwdp_a,
  output fpu_pkg::bus_sel_t                          iss_fwdp_b,
  output fpu_pkg::data_t [fpu_pkg::num_bus-1:0]      bus_cur,
  output fpu_pkg::data_t [fpu_pkg::num_bus-1:0]      bus_prev
);

  always_ff @(posedge clk) begin
    if (rst) begin
      iss_valid <= 1'b0;
    end else begin
      iss_valid <= en;
    end
  end

  // operation payload, qualified by iss_valid downstream
  always_ff @(posedge clk) begin
    iss_op     <= op;
    iss_mod    <= mod;
    iss_a      <= a;
    iss_b      <= b;
    iss_fwd_a  <= fwd_a;
    iss_fwd_b  <= fwd_b;
    iss_fwdp_a <= fwdp_a;
    iss_fwdp_b <= fwdp_b;
  end

  // bypass window: bus at the issue edge and one edge before it
  always_ff @(posedge clk) begin
    bus_cur  <= bus;
    bus_prev <= bus_cur;
  end

endmodule

//--- hdl/operand_bypass.sv
// operand bypass mux for one source operand
// picks a current bus, a previous bus or the register file value
// checks that the select vectors stay one-hot and do not mix
`timescale 1ns/1ns

module operand_bypass (
  input  logic                                       clk,
  input  logic                                       rst,
  input  fpu_pkg::data_t                             iss_rf,
  input  fpu_pkg::bus_sel_t                          sel_cur,
  input  fpu_pkg::bus_sel_t                          sel_prev,
  input  fpu_pkg::data_t [fpu_pkg::num_bus-1:0]      bus_cur,
  input  fpu_pkg::data_t [fpu_pkg::num_bus-1:0]      bus_prev,
  output fpu_pkg::data_t                             opnd
);

  fpu_pkg::data_t cur_pick;
  fpu_pkg::data_t prev_pick;
  logic           hit;

  // and-or over the eight bus candidates
  always_comb begin
    cur_pick  = '0;
    prev_pick = '0;
    for (int i = 0; i < fpu_pkg::num_bus; i++) begin
      cur_pick  = cur_pick | (bus_cur[i] & {fpu_pkg::data_w{sel_cur[i]}});
      prev_pick = prev_pick | (bus_prev[i] & {fpu_pkg::data_w{sel_prev[i]}});
    end
  end

  assign hit  = (|sel_cur) | (|sel_prev);

  // register file operand when nothing is forwarded
  assign opnd = hit ? (cur_pick | prev_pick) : iss_rf;

  a_cur_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(sel_cur));

  a_prev_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(sel_prev));

  // a bus generation is taken either now or one edge back, never both
  a_no_mix: assert property (@(posedge clk) disable iff (rst)
    !((|sel_cur) && (|sel_prev)));

endmodule

//--- hdl/fpu_exec.sv
// execute stage of the fp slice
// packed logic, lane permute and packed single equality compare
// nan and denormal lane classification for the raise flags
// result, valid and raise registered together
`timescale 1ns/1ns

module fpu_exec (
  input  logic              clk,
  input  logic              rst,
  input  logic              iss_valid,
  input  fpu_pkg::fop_t     iss_op,
  input  fpu_pkg::mod_t     iss_mod,
  input  fpu_pkg::data_t    opnd_a,
  input  fpu_pkg::data_t    opnd_b,
  output fpu_pkg::data_t    res,
  output logic              res_valid,
  output fpu_pkg::flags_t   raise
);

  logic            is_logic;
  logic            is_perm;
  logic            is_cmp;
  fpu_pkg::data_t  logic_res;
  fpu_pkg::data_t  perm_res;
  fpu_pkg::data_t  cmp_res;
  fpu_pkg::data_t  res_nxt;
  fpu_pkg::flags_t raise_nxt;
  fpu_pkg::lane_t  a_lane [2];
  fpu_pkg::lane_t  b_lane [2];
  fpu_pkg::lane_t  perm_lo;
  fpu_pkg::lane_t  perm_hi;
  logic [1:0]      lane_eq;
  logic            any_nan;
  logic            any_den;

  function automatic logic lane_nan(fpu_pkg::lane_t x);
    lane_nan = (&x[fpu_pkg::lane_w-2 -: fpu_pkg::exp_w]) && (|x[fpu_pkg::man_w-1:0]);
  endfunction

  function automatic logic lane_den(fpu_pkg::lane_t x);
    lane_den = ~(|x[fpu_pkg::lane_w-2 -: fpu_pkg::exp_w]) && (|x[fpu_pkg::man_w-1:0]);
  endfunction

  // zero of either sign
  function automatic logic lane_zero(fpu_pkg::lane_t x);
    lane_zero = ~(|x[fpu_pkg::lane_w-2:0]);
  endfunction

  // opcode groups
  assign is_logic = iss_op[7:2] == fpu_pkg::fop_logic_hi;
  assign is_perm  = iss_op == fpu_pkg::fop_perm;
  assign is_cmp   = iss_op == fpu_pkg::fop_cmpeq_s;

  assign a_lane[0] = opnd_a[fpu_pkg::lane_w-1:0];
  assign a_lane[1] = opnd_a[fpu_pkg::data_w-1:fpu_pkg::lane_w];
  assign b_lane[0] = opnd_b[fpu_pkg::lane_w-1:0];
  assign b_lane[1] = opnd_b[fpu_pkg::data_w-1:fpu_pkg::lane_w];

  // bitwise function from the low opcode bits
  always_comb begin
    case (iss_op[1:0])
      2'b00:   logic_res = opnd_a & opnd_b;
      2'b01:   logic_res = opnd_a | opnd_b;
      2'b10:   logic_res = opnd_a ^ opnd_b;
      default: logic_res = opnd_a & ~opnd_b;
    endcase
  end

  // lane copy from a or b, then optional swap
  assign perm_lo  = iss_mod[0] ? a_lane[0] : b_lane[0];
  assign perm_hi  = iss_mod[1] ? a_lane[1] : b_lane[1];
  assign perm_res = iss_mod[2] ? {perm_lo, perm_hi} : {perm_hi, perm_lo};

  always_comb begin
    any_nan = 1'b0;
    any_den = 1'b0;
    for (int l = 0; l < 2; l++) begin
      lane_eq[l] = ((a_lane[l] == b_lane[l]) && !lane_nan(a_lane[l]) && !lane_nan(b_lane[l]))
                   || (lane_zero(a_lane[l]) && lane_zero(b_lane[l]));
      any_nan = any_nan | lane_nan(a_lane[l]) | lane_nan(b_lane[l]);
      any_den = any_den | lane_den(a_lane[l]) | lane_den(b_lane[l]);
    end
  end

  // all-ones mask per equal lane
  assign cmp_res = {{fpu_pkg::lane_w{lane_eq[1]}}, {fpu_pkg::lane_w{lane_eq[0]}}};

  always_comb begin
    if (is_logic) begin
      res_nxt = logic_res;
    end else if (is_perm) begin
      res_nxt = perm_res;
    end else if (is_cmp) begin
      res_nxt = cmp_res;
    end else begin
      res_nxt = '0;
    end
  end

  // only the compare raises anything
  always_comb begin
    raise_nxt = '0;
    raise_nxt[fpu_pkg::flag_inv] = is_cmp & any_nan;
    raise_nxt[fpu_pkg::flag_den] = is_cmp & any_den;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= iss_valid;
    end
  end

  always_ff @(posedge clk) begin
    res   <= res_nxt;
    raise <= raise_nxt;
  end

  // an issued opcode must decode into one of the three groups
  a_legal_op: assert property (@(posedge clk) disable iff (rst)
    iss_valid |-> (is_logic || is_perm || is_cmp));

endmodule

//--- hdl/fpu_excpt.sv
// exception report of the fp slice
// masks raised flags with the control word enables
// and priority-encodes the lowest enabled flag
`timescale 1ns/1ns

module fpu_excpt (
  input  logic              clk,
  input  logic              res_valid,
  input  fpu_pkg::flags_t   raise,
  input  fpu_pkg::csr_t     csr,
  output fpu_pkg::excno_t   exc_no,
  output logic              exc_en
);

  fpu_pkg::flags_t masked;

  // enable field sits at csr_en_lo upward
  assign masked = raise & csr[fpu_pkg::csr_en_lo +: fpu_pkg::flag_w];

  // lowest set bit wins, numbered from one
  always_comb begin
    exc_no = '0;
    for (int i = fpu_pkg::flag_w - 1; i >= 0; i--) begin
      if (masked[i]) begin
        exc_no = fpu_pkg::excno_t'(i + 1);
      end
    end
  end

  assign exc_en = res_valid & (|masked);

  // a reported exception names an enabled raised flag
  a_exc_with_res: assert property (@(posedge clk)
    exc_en |-> (exc_no != '0 && masked[exc_no - 1'b1]));

endmodule

//--- hdl/fpu_slice.sv
// top of the fp functional-unit slice
// issue latch, two operand bypass units, execute stage and exception report
`timescale 1ns/1ns

module fpu_slice (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic                                       en,
  input  fpu_pkg::fop_t                              op,
  input  fpu_pkg::mod_t                              mod,
  input  fpu_pkg::data_t                             a,
  input  fpu_pkg::data_t                             b,
  input  fpu_pkg::bus_sel_t                          fwd_a,
  input  fpu_pkg::bus_sel_t                          fwd_b,
  input  fpu_pkg::bus_sel_t                          fwdp_a,
  input  fpu_pkg::bus_sel_t                          fwdp_b,
  input  fpu_pkg::data_t [fpu_pkg::num_bus-1:0]      bus,
  input  fpu_pkg::csr_t                              csr,
  output fpu_pkg::data_t                             res,
  output logic                                       res_valid,
  output fpu_pkg::excno_t                            exc_no,
  output logic                                       exc_en
);

  logic                                  iss_valid;
  fpu_pkg::fop_t                         iss_op;
  fpu_pkg::mod_t                         iss_mod;
  fpu_pkg::data_t                        iss_a;
  fpu_pkg::data_t                        iss_b;
  fpu_pkg::bus_sel_t                     iss_fwd_a;
  fpu_pkg::bus_sel_t                     iss_fwd_b;
  fpu_pkg::bus_sel_t                     iss_fwdp_a;
  fpu_pkg::bus_sel_t                     iss_fwdp_b;
  fpu_pkg::data_t [fpu_pkg::num_bus-1:0] bus_cur;
  fpu_pkg::data_t [fpu_pkg::num_bus-1:0] bus_prev;
  fpu_pkg::flags_t                       raise;

  // index 0 is operand a, index 1 is operand b
  fpu_pkg::data_t    [1:0] iss_rf;
  fpu_pkg::bus_sel_t [1:0] sel_cur;
  fpu_pkg::bus_sel_t [1:0] sel_prev;
  fpu_pkg::data_t    [1:0] opnd;

  assign iss_rf[0]   = iss_a;
  assign iss_rf[1]   = iss_b;
  assign sel_cur[0]  = iss_fwd_a;
  assign sel_cur[1]  = iss_fwd_b;
  assign sel_prev[0] = iss_fwdp_a;
  assign sel_prev[1] = iss_fwdp_b;

  issue_latch u_issue (
    .clk(clk), .rst(rst), .en(en), .op(op), .mod(mod), .a(a), .b(b),
    .fwd_a(fwd_a), .fwd_b(fwd_b), .fwdp_a(fwdp_a), .fwdp_b(fwdp_b), .bus(bus),
    .iss_valid(iss_valid), .iss_op(iss_op), .iss_mod(iss_mod),
    .iss_a(iss_a), .iss_b(iss_b),
    .iss_fwd_a(iss_fwd_a), .iss_fwd_b(iss_fwd_b),
    .iss_fwdp_a(iss_fwdp_a), .iss_fwdp_b(iss_fwdp_b),
    .bus_cur(bus_cur), .bus_prev(bus_prev)
  );

  for (genvar g = 0; g < 2; g++) begin : g_byp
    operand_bypass u_byp (
      .clk(clk), .rst(rst), .iss_rf(iss_rf[g]),
      .sel_cur(sel_cur[g]), .sel_prev(sel_prev[g]),
      .bus_cur(bus_cur), .bus_prev(bus_prev), .opnd(opnd[g])
    );
  end

  fpu_exec u_exec (
    .clk(clk), .rst(rst), .iss_valid(iss_valid), .iss_op(iss_op), .iss_mod(iss_mod),
    .opnd_a(opnd[0]), .opnd_b(opnd[1]),
    .res(res), .res_valid(res_valid), .raise(raise)
  );

  fpu_excpt u_excpt (
    .clk(clk), .res_valid(res_valid), .raise(raise), .csr(csr),
    .exc_no(exc_no), .exc_en(exc_en)
  );

endmodule

//--- verification/fpu_checker.sv
// result checker for the fp slice
// reference model of bypass, logic, permute, compare and exception masking
// expected-result queue compared two edges after each issue
`timescale 1ns/1ns

module fpu_checker (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic                                       en,
  input  fpu_pkg::fop_t                              op,
  input  fpu_pkg::mod_t                              mod,
  input  fpu_pkg::data_t                             a,
  input  fpu_pkg::data_t                             b,
  input  fpu_pkg::bus_sel_t                          fwd_a,
  input  fpu_pkg::bus_sel_t                          fwd_b,
  input  fpu_pkg::bus_sel_t                          fwdp_a,
  input  fpu_pkg::bus_sel_t                          fwdp_b,
  input  fpu_pkg::data_t [fpu_pkg::num_bus-1:0]      bus,
  input  fpu_pkg::csr_t                              csr,
  input  fpu_pkg::data_t                             res,
  input  logic                                       res_valid,
  input  fpu_pkg::excno_t                            exc_no,
  input  logic                                       exc_en,
  output int                                         errors,
  output int                                         checked
);

  int err_cnt = 0;
  int chk_cnt = 0;
  int cycle = 0;
  logic rst_d = 1'b0;
  logic armed = 1'b0;
  fpu_pkg::data_t [fpu_pkg::num_bus-1:0] bus_last = '0;

  fpu_pkg::data_t  res_q [$];
  fpu_pkg::flags_t raise_q [$];
  int              due_q [$];
  string           name_q [$];

  assign errors  = err_cnt;
  assign checked = chk_cnt;

  // ieee single layout: sign 31, exponent 30..23, fraction 22..0
  function automatic logic is_nan32(fpu_pkg::lane_t x);
    return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
  endfunction

  function automatic logic is_den32(fpu_pkg::lane_t x);
    return (x[30:23] == 8'h00) && (x[22:0] != 23'd0);
  endfunction

  function automatic logic is_zero32(fpu_pkg::lane_t x);
    return x[30:0] == 31'd0;
  endfunction

  // current select wins the bus now, previous select the bus one edge back
  function automatic fpu_pkg::data_t pick_operand(
    fpu_pkg::data_t rf, fpu_pkg::bus_sel_t cur, fpu_pkg::bus_sel_t prev,
    fpu_pkg::data_t [fpu_pkg::num_bus-1:0] now, fpu_pkg::data_t [fpu_pkg::num_bus-1:0] old);
    fpu_pkg::data_t v;
    v = rf;
    for (int i = 0; i < fpu_pkg::num_bus; i++) begin
      if (cur[i]) v = now[i];
      if (prev[i]) v = old[i];
    end
    return v;
  endfunction

  function automatic fpu_pkg::data_t ref_result(
    input fpu_pkg::fop_t f, input fpu_pkg::mod_t m,
    input fpu_pkg::data_t x, input fpu_pkg::data_t y, output fpu_pkg::flags_t flags);
    fpu_pkg::lane_t xl [2];
    fpu_pkg::lane_t yl [2];
    fpu_pkg::lane_t lo;
    fpu_pkg::lane_t hi;
    fpu_pkg::data_t r;
    flags = '0;
    r = '0;
    xl[0] = x[31:0];
    xl[1] = x[63:32];
    yl[0] = y[31:0];
    yl[1] = y[63:32];
    case (f)
      fpu_pkg::fop_and:  r = x & y;
      fpu_pkg::fop_or:   r = x | y;
      fpu_pkg::fop_xor:  r = x ^ y;
      fpu_pkg::fop_andn: r = x & ~y;
      fpu_pkg::fop_perm: begin
        lo = m[0] ? xl[0] : yl[0];
        hi = m[1] ? xl[1] : yl[1];
        r  = m[2] ? {lo, hi} : {hi, lo};
      end
      fpu_pkg::fop_cmpeq_s: begin
        for (int l = 0; l < 2; l++) begin
          if ((xl[l] == yl[l] && !is_nan32(xl[l]) && !is_nan32(yl[l])) ||
              (is_zero32(xl[l]) && is_zero32(yl[l]))) begin
            r[l*32 +: 32] = '1;
          end
          if (is_nan32(xl[l]) || is_nan32(yl[l])) flags[fpu_pkg::flag_inv] = 1'b1;
          if (is_den32(xl[l]) || is_den32(yl[l])) flags[fpu_pkg::flag_den] = 1'b1;
        end
      end
      default: r = '0;
    endcase
    return r;
  endfunction

  // lowest enabled raised flag, numbered from one
  function automatic fpu_pkg::excno_t ref_exc_no(fpu_pkg::flags_t raise, fpu_pkg::csr_t c);
    fpu_pkg::flags_t m;
    fpu_pkg::excno_t n;
    m = raise & c[fpu_pkg::csr_en_lo +: fpu_pkg::flag_w];
    n = '0;
    for (int i = 0; i < fpu_pkg::flag_w; i++) begin
      if (m[i] && n == '0) n = fpu_pkg::excno_t'(i + 1);
    end
    return n;
  endfunction

  always @(posedge clk) begin
    fpu_pkg::data_t  opa;
    fpu_pkg::data_t  opb;
    fpu_pkg::data_t  want;
    fpu_pkg::flags_t fl;
    fpu_pkg::excno_t want_no;
    cycle++;
    if (!armed) begin
      // outputs are unknown before the first reset edge
    end else if (rst_d) begin
      if (res_valid !== 1'b0 || exc_en !== 1'b0) begin
        err_cnt++;
        $display("Error at %0t ns: res_valid or exc_en not low under reset", $time);
      end
    end else if (res_valid === 1'b1) begin
      if (due_q.size() == 0 || due_q[0] != cycle) begin
        err_cnt++;
        $display("Error at %0t ns: res_valid with no operation due", $time);
      end else begin
        want = res_q.pop_front();
        fl = raise_q.pop_front();
        void'(due_q.pop_front());
        want_no = ref_exc_no(fl, csr);
        chk_cnt++;
        if (res !== want) begin
          err_cnt++;
          $display("Error at %0t ns: %s res %h expected %h", $time, name_q[0], res, want);
        end
        if (exc_en !== (want_no != '0)) begin
          err_cnt++;
          $display("Error at %0t ns: %s exc_en %b expected %b", $time, name_q[0],
                   exc_en, want_no != '0);
        end else if (exc_no !== want_no) begin
          err_cnt++;
          $display("Error at %0t ns: %s exc_no %0d expected %0d", $time, name_q[0],
                   exc_no, want_no);
        end
        void'(name_q.pop_front());
      end
    end else begin
      if (res_valid !== 1'b0 || exc_en !== 1'b0) begin
        err_cnt++;
        $display("Error at %0t ns: res_valid %b exc_en %b while idle", $time,
                 res_valid, exc_en);
      end
      if (due_q.size() != 0 && due_q[0] == cycle) begin
        err_cnt++;
        $display("Error at %0t ns: %s result missing", $time, name_q[0]);
        void'(res_q.pop_front());
        void'(raise_q.pop_front());
        void'(due_q.pop_front());
        void'(name_q.pop_front());
      end
    end
    if (!rst && en) begin
      opa = pick_operand(a, fwd_a, fwdp_a, bus, bus_last);
      opb = pick_operand(b, fwd_b, fwdp_b, bus, bus_last);
      want = ref_result(op, mod, opa, opb, fl);
      res_q.push_back(want);
      raise_q.push_back(fl);
      due_q.push_back(cycle + 2);
      name_q.push_back(op.name());
    end
    bus_last = bus;
    rst_d = rst;
    if (rst) armed = 1'b1;
  end

endmodule

//--- verification/fpu_slice_tb.sv
// testbench top for the fp slice
// clock, reset, lfsr stimulus with bus model, timeout and closing report
`timescale 1ns/1ns

module fpu_slice_tb;

  localparam int num_ops = 400;
  localparam int max_cycles = num_ops * 3 + 100;

  logic clk = 1'b0;
  logic rst;
  logic en;
  fpu_pkg::fop_t op;
  fpu_pkg::mod_t mod;
  fpu_pkg::data_t a;
  fpu_pkg::data_t b;
  fpu_pkg::bus_sel_t fwd_a;
  fpu_pkg::bus_sel_t fwd_b;
  fpu_pkg::bus_sel_t fwdp_a;
  fpu_pkg::bus_sel_t fwdp_b;
  fpu_pkg::data_t [fpu_pkg::num_bus-1:0] bus;
  fpu_pkg::csr_t csr;
  fpu_pkg::data_t res;
  logic res_valid;
  fpu_pkg::excno_t exc_no;
  logic exc_en;
  int errors;
  int checked;
  int cycle_count = 0;
  logic [31:0] lfsr = 32'h5f9cc20d;

  always #20 clk = ~clk;

  fpu_slice dut (
    .clk(clk), .rst(rst), .en(en), .op(op), .mod(mod), .a(a), .b(b),
    .fwd_a(fwd_a), .fwd_b(fwd_b), .fwdp_a(fwdp_a), .fwdp_b(fwdp_b),
    .bus(bus), .csr(csr),
    .res(res), .res_valid(res_valid), .exc_no(exc_no), .exc_en(exc_en)
  );

  fpu_checker chk (
    .clk(clk), .rst(rst), .en(en), .op(op), .mod(mod), .a(a), .b(b),
    .fwd_a(fwd_a), .fwd_b(fwd_b), .fwdp_a(fwdp_a), .fwdp_b(fwdp_b),
    .bus(bus), .csr(csr),
    .res(res), .res_valid(res_valid), .exc_no(exc_no), .exc_en(exc_en),
    .errors(errors), .checked(checked)
  );

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [63:0] next_bits(input int n);
    logic [63:0] v;
    logic fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v = {v[62:0], fb};
    end
    return v;
  endfunction

  task automatic drive_buses();
    for (int i = 0; i < fpu_pkg::num_bus; i++) begin
      bus[i] = next_bits(64);
    end
  endtask

  // register file, current bus or previous bus, never both
  task automatic pick_sel(output fpu_pkg::bus_sel_t cur, output fpu_pkg::bus_sel_t prev);
    logic [1:0] how;
    logic [1:0] idx;
    how = 2'(next_bits(2));
    idx = 2'(next_bits(2));
    cur = '0;
    prev = '0;
    if (how == 2'd2) cur = fpu_pkg::bus_sel_t'(1 << idx);
    if (how == 2'd3) prev = fpu_pkg::bus_sel_t'(1 << idx);
  endtask

  // lane pairs leaning to equal values, zeros, nans and denormals
  task automatic cmp_lanes(output fpu_pkg::lane_t la, output fpu_pkg::lane_t lb);
    logic [2:0] kind;
    logic [31:0] r;
    kind = 3'(next_bits(3));
    r = 32'(next_bits(32));
    case (kind)
      3'd0, 3'd1: begin
        la = r;
        lb = r;
      end
      3'd2: begin
        la = {r[31], 31'b0};
        lb = {r[30], 31'b0};
      end
      3'd3: begin
        la = {r[31], 8'hff, r[22:1], 1'b1};
        lb = r[0] ? la : fpu_pkg::lane_t'(next_bits(32));
      end
      3'd4: begin
        la = {r[31], 8'h00, r[22:1], 1'b1};
        lb = r[0] ? la : fpu_pkg::lane_t'(next_bits(32));
      end
      3'd5: begin
        la = {r[31], 8'hff, 23'b0};
        lb = {r[31] ^ r[0], 8'hff, 23'b0};
      end
      default: begin
        la = r;
        lb = fpu_pkg::lane_t'(next_bits(32));
      end
    endcase
  endtask

  task automatic issue_op();
    logic [2:0] kind;
    fpu_pkg::lane_t la0;
    fpu_pkg::lane_t lb0;
    fpu_pkg::lane_t la1;
    fpu_pkg::lane_t lb1;
    kind = 3'(next_bits(3));
    case (kind)
      3'd0: op = fpu_pkg::fop_and;
      3'd1: op = fpu_pkg::fop_or;
      3'd2: op = fpu_pkg::fop_xor;
      3'd3: op = fpu_pkg::fop_andn;
      3'd4: op = fpu_pkg::fop_perm;
      default: op = fpu_pkg::fop_cmpeq_s;
    endcase
    mod = fpu_pkg::mod_t'(next_bits(3));
    csr = fpu_pkg::csr_t'(next_bits(32));
    if (op == fpu_pkg::fop_cmpeq_s) begin
      cmp_lanes(la0, lb0);
      cmp_lanes(la1, lb1);
      a = {la1, la0};
      b = {lb1, lb0};
    end else begin
      a = next_bits(64);
      b = next_bits(64);
    end
    pick_sel(fwd_a, fwdp_a);
    pick_sel(fwd_b, fwdp_b);
    en = 1'b1;
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("timeout: run stopped after %0d cycles, %0d of %0d results checked",
               cycle_count, checked, num_ops);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  initial begin
    logic [1:0] gap;
    rst = 1'b1;
    en = 1'b0;
    op = fpu_pkg::fop_and;
    mod = '0;
    a = '0;
    b = '0;
    fwd_a = '0;
    fwd_b = '0;
    fwdp_a = '0;
    fwdp_b = '0;
    bus = '0;
    csr = '0;
    repeat (10) begin
      @(negedge clk);
      drive_buses();
    end
    rst = 1'b0;
    for (int n = 0; n < num_ops; n++) begin
      @(negedge clk);
      drive_buses();
      issue_op();
      // mostly back to back, sometimes one or two idle cycles
      gap = 2'(next_bits(2));
      repeat ((gap == 2'd0) ? 0 : int'(gap) - 1) begin
        @(negedge clk);
        drive_buses();
        en = 1'b0;
      end
    end
    while (checked < num_ops) begin
      @(negedge clk);
      drive_buses();
      en = 1'b0;
    end
    repeat (2) @(negedge clk);
    $display("closing: %0d of %0d results checked, %0d errors", checked, num_ops, errors);
    if (errors == 0 && checked == num_ops) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- flist.f
hdl/fpu_pkg.sv
hdl/issue_latch.sv
hdl/operand_bypass.sv
hdl/fpu_exec.sv
hdl/fpu_excpt.sv
hdl/fpu_slice.sv
verification/fpu_checker.sv
verification/fpu_slice_tb.sv

//--- run.sh
#!/bin/sh
# builds the fp slice testbench with verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module fpu_slice_tb -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vfpu_slice_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^ALL CHECKS PASSED$"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
